/* source/mcoc_bus_pkg.sv */
`default_nettype none

package mcoc_bus_pkg;

	typedef logic [15:0] bus_addr_t;	// Word address
	typedef logic [15:0] bus_data_t;	// Bus data word
	typedef logic [3:0]  reg_ofs_t;		// Register offset in a block

	// Request from the bus master, 34 bits
	typedef struct packed {
		logic      rd;		// Read strobe
		logic      wr;		// Write strobe
		bus_addr_t addr;
		bus_data_t wdata;
	} bus_req_t;

	// One-hot block selects
	typedef struct packed {
		logic intc;
		logic idrg;
		logic port;
		logic tim0;
		logic tim1;
	} blk_sel_t;

	// Decoded request seen by all peripherals, 27 bits
	typedef struct packed {
		blk_sel_t  sel;
		logic      rd;
		logic      wr;
		reg_ofs_t  ofs;
		bus_data_t wdata;
	} dec_req_t;

	// Block bases, 16 registers each
	localparam bus_addr_t INTC_BASE = 16'hFE00;
	localparam bus_addr_t IDRG_BASE = 16'hFE10;
	localparam bus_addr_t PORT_BASE = 16'hFE20;
	localparam bus_addr_t TIM0_BASE = 16'hFE30;
	localparam bus_addr_t TIM1_BASE = 16'hFE40;

endpackage

`default_nettype wire

/* source/mcoc_periph_pkg.sv */
`default_nettype none

package mcoc_periph_pkg;

	// ID block
	localparam mcoc_bus_pkg::bus_data_t ID_IDCODE     = 16'h1150;
	localparam mcoc_bus_pkg::bus_data_t ID_VERSNO     = 16'h0148;
	localparam mcoc_bus_pkg::reg_ofs_t  ID_OFS_IDCODE = 4'd0;
	localparam mcoc_bus_pkg::reg_ofs_t  ID_OFS_VERSNO = 4'd1;

	// Timer registers
	localparam mcoc_bus_pkg::reg_ofs_t TIM_CTRL   = 4'd0;	// b0 enable, b1 clear
	localparam mcoc_bus_pkg::reg_ofs_t TIM_PERIOD = 4'd1;
	localparam mcoc_bus_pkg::reg_ofs_t TIM_CMPA   = 4'd2;
	localparam mcoc_bus_pkg::reg_ofs_t TIM_CMPB   = 4'd3;
	localparam mcoc_bus_pkg::reg_ofs_t TIM_COUNT  = 4'd4;	// Read only

	// Port registers
	localparam mcoc_bus_pkg::reg_ofs_t PORT_OUT = 4'd0;
	localparam mcoc_bus_pkg::reg_ofs_t PORT_ENB = 4'd1;
	localparam mcoc_bus_pkg::reg_ofs_t PORT_IN  = 4'd2;	// Read only

	// Interrupt controller registers
	localparam mcoc_bus_pkg::reg_ofs_t INTC_FLAG = 4'd0;	// Write 1 to clear
	localparam mcoc_bus_pkg::reg_ofs_t INTC_ENB  = 4'd1;
	localparam mcoc_bus_pkg::reg_ofs_t INTC_VEC  = 4'd2;	// Read only

	// Timer event pulses
	typedef struct packed {
		logic ovf;	// Count wrap
		logic cma;	// Compare A match
		logic cmb;	// Compare B match
	} tim_evt_t;

	localparam int INT_FACTORS = 8;
	typedef logic [$clog2(INT_FACTORS)-1:0] int_vec_t;

	// Factor indices
	localparam int INT_EXT0   = 0;
	localparam int INT_EXT1   = 1;
	localparam int INT_T0_OVF = 2;
	localparam int INT_T0_CMA = 3;
	localparam int INT_T0_CMB = 4;
	localparam int INT_T1_OVF = 5;
	localparam int INT_T1_CMA = 6;
	localparam int INT_T1_CMB = 7;

endpackage

`default_nettype wire

/* source/mcoc_bus_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module mcoc_bus_decode (
	input  logic                   clk,
	input  logic                   rst_i,
	input  mcoc_bus_pkg::bus_req_t bus_req_i,
	output logic                   bus_rdy_o,
	output mcoc_bus_pkg::dec_req_t dec_req_o
);

	mcoc_bus_pkg::blk_sel_t  sel_c;	// Address compare result
	mcoc_bus_pkg::blk_sel_t  sel_q;
	logic                    rd_q;
	logic                    wr_q;
	mcoc_bus_pkg::reg_ofs_t  ofs_q;
	mcoc_bus_pkg::bus_data_t wdata_q;
	logic                    accept;

	assign accept = bus_rdy_o & (bus_req_i.rd | bus_req_i.wr);	// No back-pressure

	// Upper 12 bits pick the block
	always_comb begin
		sel_c      = '0;
		sel_c.intc = (bus_req_i.addr[15:4] == mcoc_bus_pkg::INTC_BASE[15:4]);
		sel_c.idrg = (bus_req_i.addr[15:4] == mcoc_bus_pkg::IDRG_BASE[15:4]);
		sel_c.port = (bus_req_i.addr[15:4] == mcoc_bus_pkg::PORT_BASE[15:4]);
		sel_c.tim0 = (bus_req_i.addr[15:4] == mcoc_bus_pkg::TIM0_BASE[15:4]);
		sel_c.tim1 = (bus_req_i.addr[15:4] == mcoc_bus_pkg::TIM1_BASE[15:4]);
	end

	// Ready comes up one cycle after reset release
	always_ff @(posedge clk) begin
		if (rst_i) begin
			bus_rdy_o <= 1'b0;
		end else begin
			bus_rdy_o <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			sel_q <= '0;
			rd_q  <= 1'b0;
			wr_q  <= 1'b0;
		end else begin
			sel_q <= accept ? sel_c : '0;	// Unmapped gives no select
			rd_q  <= accept & bus_req_i.rd;
			wr_q  <= accept & bus_req_i.wr;
		end
	end

	always_ff @(posedge clk) begin
		ofs_q   <= bus_req_i.addr[3:0];
		wdata_q <= bus_req_i.wdata;
	end

	assign dec_req_o = '{sel: sel_q, rd: rd_q, wr: wr_q, ofs: ofs_q, wdata: wdata_q};

endmodule

`default_nettype wire

/* source/mcoc_timer_pwm.sv */
`timescale 1ns/1ns
`default_nettype none

module mcoc_timer_pwm (
	input  logic                      clk,
	input  logic                      rst_i,
	input  logic                      sel_i,
	input  mcoc_bus_pkg::dec_req_t    dec_req_i,
	output mcoc_bus_pkg::bus_data_t   rdata_o,
	output logic                      pwma_o,
	output logic                      pwmb_o,
	output mcoc_periph_pkg::tim_evt_t evt_o
);

	logic                    en_q;	// CTRL bit 0
	mcoc_bus_pkg::bus_data_t period_q;
	mcoc_bus_pkg::bus_data_t cmpa_q;
	mcoc_bus_pkg::bus_data_t cmpb_q;
	mcoc_bus_pkg::bus_data_t count_q;
	logic                    wr_hit;
	logic                    cnt_clr;
	logic                    wrap;

	assign wr_hit  = sel_i & dec_req_i.wr;
	assign cnt_clr = wr_hit & (dec_req_i.ofs == mcoc_periph_pkg::TIM_CTRL) & dec_req_i.wdata[1];
	assign wrap    = (count_q >= period_q);	// Also recovers if PERIOD drops below count

	// Register writes
	always_ff @(posedge clk) begin
		if (rst_i) begin
			en_q     <= 1'b0;
			period_q <= '0;
			cmpa_q   <= '0;
			cmpb_q   <= '0;
		end else if (wr_hit) begin
			case (dec_req_i.ofs)
				mcoc_periph_pkg::TIM_CTRL:   en_q     <= dec_req_i.wdata[0];
				mcoc_periph_pkg::TIM_PERIOD: period_q <= dec_req_i.wdata;
				mcoc_periph_pkg::TIM_CMPA:   cmpa_q   <= dec_req_i.wdata;
				mcoc_periph_pkg::TIM_CMPB:   cmpb_q   <= dec_req_i.wdata;
				default: ;	// COUNT is read only
			endcase
		end
	end

	// Counter, period is PERIOD+1 cycles
	always_ff @(posedge clk) begin
		if (rst_i || cnt_clr) begin
			count_q <= '0;
		end else if (en_q) begin
			count_q <= wrap ? '0 : count_q + 1'b1;
		end
	end

	// PWM levels and event pulses, all registered
	always_ff @(posedge clk) begin
		if (rst_i) begin
			pwma_o <= 1'b0;
			pwmb_o <= 1'b0;
			evt_o  <= '0;
		end else begin
			pwma_o    <= en_q & (count_q < cmpa_q);
			pwmb_o    <= en_q & (count_q < cmpb_q);
			evt_o.ovf <= en_q & wrap;
			evt_o.cma <= en_q & (count_q == cmpa_q);
			evt_o.cmb <= en_q & (count_q == cmpb_q);
		end
	end

	// Read mux, zero when not addressed
	always_comb begin
		rdata_o = '0;
		if (sel_i && dec_req_i.rd) begin
			case (dec_req_i.ofs)
				mcoc_periph_pkg::TIM_CTRL:   rdata_o = {15'h0, en_q};
				mcoc_periph_pkg::TIM_PERIOD: rdata_o = period_q;
				mcoc_periph_pkg::TIM_CMPA:   rdata_o = cmpa_q;
				mcoc_periph_pkg::TIM_CMPB:   rdata_o = cmpb_q;
				mcoc_periph_pkg::TIM_COUNT:  rdata_o = count_q;
				default:                     rdata_o = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/mcoc_gpio_port.sv */
`timescale 1ns/1ns
`default_nettype none

module mcoc_gpio_port (
	input  logic                    clk,
	input  logic                    rst_i,
	input  logic                    sel_i,
	input  mcoc_bus_pkg::dec_req_t  dec_req_i,
	input  logic [7:0]              port_in_i,
	output logic [7:0]              port_out_o,
	output logic [7:0]              port_enb_o,
	output mcoc_bus_pkg::bus_data_t rdata_o
);

	logic [7:0] in_s1;	// First sync stage
	logic [7:0] in_s2;	// Value seen by PORT_IN
	logic       wr_hit;

	assign wr_hit = sel_i & dec_req_i.wr;

	// Output and enable registers, pins start as inputs
	always_ff @(posedge clk) begin
		if (rst_i) begin
			port_out_o <= '0;
			port_enb_o <= '0;
		end else if (wr_hit) begin
			if (dec_req_i.ofs == mcoc_periph_pkg::PORT_OUT) begin
				port_out_o <= dec_req_i.wdata[7:0];
			end
			if (dec_req_i.ofs == mcoc_periph_pkg::PORT_ENB) begin
				port_enb_o <= dec_req_i.wdata[7:0];
			end
		end
	end

	// Two-stage pin synchronizer
	always_ff @(posedge clk) begin
		if (rst_i) begin
			in_s1 <= '0;
			in_s2 <= '0;
		end else begin
			in_s1 <= port_in_i;
			in_s2 <= in_s1;
		end
	end

	always_comb begin
		rdata_o = '0;
		if (sel_i && dec_req_i.rd) begin
			case (dec_req_i.ofs)
				mcoc_periph_pkg::PORT_OUT: rdata_o = {8'h0, port_out_o};
				mcoc_periph_pkg::PORT_ENB: rdata_o = {8'h0, port_enb_o};
				mcoc_periph_pkg::PORT_IN:  rdata_o = {8'h0, in_s2};
				default:                   rdata_o = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/mcoc_intc.sv */
`timescale 1ns/1ns
`default_nettype none

module mcoc_intc (
	input  logic                      clk,
	input  logic                      rst_i,
	input  logic                      sel_i,
	input  mcoc_bus_pkg::dec_req_t    dec_req_i,
	input  logic [1:0]                ext_int_i,
	input  mcoc_periph_pkg::tim_evt_t tim0_evt_i,
	input  mcoc_periph_pkg::tim_evt_t tim1_evt_i,
	output mcoc_bus_pkg::bus_data_t   rdata_o,
	output logic                      irq_o
);

	localparam int NF = mcoc_periph_pkg::INT_FACTORS;

	logic [1:0]                ext_s1;
	logic [1:0]                ext_s2;
	logic [1:0]                ext_s3;	// Previous level for edge detect
	logic [NF-1:0]             fct;	// Event per factor
	logic [NF-1:0]             flag_q;
	logic [NF-1:0]             enb_q;
	logic [NF-1:0]             clr;
	logic [NF-1:0]             pend;
	mcoc_periph_pkg::int_vec_t vec_c;
	logic                      wr_hit;

	assign wr_hit = sel_i & dec_req_i.wr;
	assign clr    = (wr_hit && dec_req_i.ofs == mcoc_periph_pkg::INTC_FLAG) ?
			dec_req_i.wdata[NF-1:0] : '0;
	assign pend   = flag_q & enb_q;

	// External pins synchronized, rising edge only
	always_ff @(posedge clk) begin
		if (rst_i) begin
			ext_s1 <= '0;
			ext_s2 <= '0;
			ext_s3 <= '0;
		end else begin
			ext_s1 <= ext_int_i;
			ext_s2 <= ext_s1;
			ext_s3 <= ext_s2;
		end
	end

	always_comb begin
		fct                              = '0;
		fct[mcoc_periph_pkg::INT_EXT0]   = ext_s2[0] & ~ext_s3[0];
		fct[mcoc_periph_pkg::INT_EXT1]   = ext_s2[1] & ~ext_s3[1];
		fct[mcoc_periph_pkg::INT_T0_OVF] = tim0_evt_i.ovf;
		fct[mcoc_periph_pkg::INT_T0_CMA] = tim0_evt_i.cma;
		fct[mcoc_periph_pkg::INT_T0_CMB] = tim0_evt_i.cmb;
		fct[mcoc_periph_pkg::INT_T1_OVF] = tim1_evt_i.ovf;
		fct[mcoc_periph_pkg::INT_T1_CMA] = tim1_evt_i.cma;
		fct[mcoc_periph_pkg::INT_T1_CMB] = tim1_evt_i.cmb;
	end

	// Sticky flags, a new event wins over a clear
	always_ff @(posedge clk) begin
		if (rst_i) begin
			flag_q <= '0;
			enb_q  <= '0;
			irq_o  <= 1'b0;
		end else begin
			flag_q <= (flag_q & ~clr) | fct;
			if (wr_hit && dec_req_i.ofs == mcoc_periph_pkg::INTC_ENB) begin
				enb_q <= dec_req_i.wdata[NF-1:0];
			end
			irq_o <= |pend;
		end
	end

	// Lowest pending index has priority
	always_comb begin
		vec_c = '0;
		for (int i = NF - 1; i >= 0; i--) begin
			if (pend[i]) begin
				vec_c = mcoc_periph_pkg::int_vec_t'(i);
			end
		end
	end

	always_comb begin
		rdata_o = '0;
		if (sel_i && dec_req_i.rd) begin
			case (dec_req_i.ofs)
				mcoc_periph_pkg::INTC_FLAG: rdata_o = mcoc_bus_pkg::bus_data_t'(flag_q);
				mcoc_periph_pkg::INTC_ENB:  rdata_o = mcoc_bus_pkg::bus_data_t'(enb_q);
				mcoc_periph_pkg::INTC_VEC:  rdata_o = mcoc_bus_pkg::bus_data_t'(vec_c);
				default:                    rdata_o = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/mcoc_bus_return.sv */
`timescale 1ns/1ns
`default_nettype none

module mcoc_bus_return (
	input  logic                    clk,
	input  logic                    rst_i,
	input  mcoc_bus_pkg::dec_req_t  dec_req_i,
	input  mcoc_bus_pkg::bus_data_t tim0_rdata_i,
	input  mcoc_bus_pkg::bus_data_t tim1_rdata_i,
	input  mcoc_bus_pkg::bus_data_t port_rdata_i,
	input  mcoc_bus_pkg::bus_data_t intc_rdata_i,
	output mcoc_bus_pkg::bus_data_t rdata_o,
	output logic                    rvalid_o
);

	mcoc_bus_pkg::bus_data_t idrg_rdata;	// ID block read word
	mcoc_bus_pkg::bus_data_t or_q;	// First return stage
	logic                    rd_q;

	always_comb begin
		idrg_rdata = '0;
		if (dec_req_i.sel.idrg && dec_req_i.rd) begin
			case (dec_req_i.ofs)
				mcoc_periph_pkg::ID_OFS_IDCODE: idrg_rdata = mcoc_periph_pkg::ID_IDCODE;
				mcoc_periph_pkg::ID_OFS_VERSNO: idrg_rdata = mcoc_periph_pkg::ID_VERSNO;
				default:                        idrg_rdata = '0;
			endcase
		end
	end

	// Idle sources drive zero, so a plain OR merges them
	always_ff @(posedge clk) begin
		or_q    <= idrg_rdata | tim0_rdata_i | tim1_rdata_i | port_rdata_i | intc_rdata_i;
		rdata_o <= or_q;	// Second stage gives the fixed 2-cycle latency
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			rd_q     <= 1'b0;
			rvalid_o <= 1'b0;
		end else begin
			rd_q     <= dec_req_i.rd;	// Unmapped reads still return zero
			rvalid_o <= rd_q;
		end
	end

endmodule

`default_nettype wire

/* source/mcoc_lite_top.sv */
`timescale 1ns/1ns
`default_nettype none

module mcoc_lite_top (
	input  logic                    clk,
	input  logic                    rst_i,
	input  mcoc_bus_pkg::bus_req_t  bus_req_i,
	output logic                    bus_rdy_o,
	output mcoc_bus_pkg::bus_data_t rdata_o,
	output logic                    rvalid_o,
	input  logic [7:0]              port_in_i,
	output logic [7:0]              port_out_o,
	output logic [7:0]              port_enb_o,
	input  logic [1:0]              ext_int_i,
	output logic                    tim0_pwma_o,
	output logic                    tim0_pwmb_o,
	output logic                    tim1_pwma_o,
	output logic                    tim1_pwmb_o,
	output logic                    irq_o
);

	mcoc_bus_pkg::dec_req_t    dec_req;	// Shared by all peripherals
	mcoc_bus_pkg::bus_data_t   tim0_rdata;
	mcoc_bus_pkg::bus_data_t   tim1_rdata;
	mcoc_bus_pkg::bus_data_t   port_rdata;
	mcoc_bus_pkg::bus_data_t   intc_rdata;
	mcoc_periph_pkg::tim_evt_t tim0_evt;
	mcoc_periph_pkg::tim_evt_t tim1_evt;

	mcoc_bus_decode u_decode (
		.clk       (clk),
		.rst_i     (rst_i),
		.bus_req_i (bus_req_i),
		.bus_rdy_o (bus_rdy_o),
		.dec_req_o (dec_req)
	);

	mcoc_timer_pwm u_tim0 (
		.clk       (clk),
		.rst_i     (rst_i),
		.sel_i     (dec_req.sel.tim0),
		.dec_req_i (dec_req),
		.rdata_o   (tim0_rdata),
		.pwma_o    (tim0_pwma_o),
		.pwmb_o    (tim0_pwmb_o),
		.evt_o     (tim0_evt)
	);

	mcoc_timer_pwm u_tim1 (
		.clk       (clk),
		.rst_i     (rst_i),
		.sel_i     (dec_req.sel.tim1),
		.dec_req_i (dec_req),
		.rdata_o   (tim1_rdata),
		.pwma_o    (tim1_pwma_o),
		.pwmb_o    (tim1_pwmb_o),
		.evt_o     (tim1_evt)
	);

	mcoc_gpio_port u_port (
		.clk        (clk),
		.rst_i      (rst_i),
		.sel_i      (dec_req.sel.port),
		.dec_req_i  (dec_req),
		.port_in_i  (port_in_i),
		.port_out_o (port_out_o),
		.port_enb_o (port_enb_o),
		.rdata_o    (port_rdata)
	);

	mcoc_intc u_intc (
		.clk        (clk),
		.rst_i      (rst_i),
		.sel_i      (dec_req.sel.intc),
		.dec_req_i  (dec_req),
		.ext_int_i  (ext_int_i),
		.tim0_evt_i (tim0_evt),
		.tim1_evt_i (tim1_evt),
		.rdata_o    (intc_rdata),
		.irq_o      (irq_o)
	);

	mcoc_bus_return u_return (
		.clk          (clk),
		.rst_i        (rst_i),
		.dec_req_i    (dec_req),
		.tim0_rdata_i (tim0_rdata),
		.tim1_rdata_i (tim1_rdata),
		.port_rdata_i (port_rdata),
		.intc_rdata_i (intc_rdata),
		.rdata_o      (rdata_o),
		.rvalid_o     (rvalid_o)
	);

endmodule

`default_nettype wire

/* verification/mcoc_lite_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module mcoc_lite_sva (
	input logic                   clk,
	input logic                   rst_i,
	input mcoc_bus_pkg::bus_req_t bus_req_i,
	input logic                   bus_rdy_o,
	input logic                   rvalid_o,
	input logic                   irq_o,
	input logic [7:0]             intc_enb_i
);

	logic rd_accept;	// Read taken at this edge
	logic any_accept;

	assign rd_accept  = bus_rdy_o & bus_req_i.rd;
	assign any_accept = bus_rdy_o & (bus_req_i.rd | bus_req_i.wr);

	// Decode stage, then two return stages
	rvalid_after_read: assert property (@(posedge clk) disable iff (rst_i)
		$past(rd_accept, 2) |=> rvalid_o)
		else $error("rvalid_o missing 2 cycles after an accepted read");

	rvalid_only_for_read: assert property (@(posedge clk) disable iff (rst_i)
		rvalid_o |-> $past(rd_accept, 3))
		else $error("rvalid_o without an accepted read");

	rd_wr_exclusive: assert property (@(posedge clk) disable iff (rst_i)
		any_accept |-> !(bus_req_i.rd && bus_req_i.wr))
		else $error("Request accepted with rd and wr both set");

	// irq_o lags the mask by one register
	irq_masked: assert property (@(posedge clk) disable iff (rst_i)
		(intc_enb_i == 8'h00 && $past(intc_enb_i) == 8'h00) |-> !irq_o)
		else $error("irq_o high while all interrupt enables are zero");

endmodule

bind mcoc_lite_top mcoc_lite_sva u_sva (
	.clk        (clk),
	.rst_i      (rst_i),
	.bus_req_i  (bus_req_i),
	.bus_rdy_o  (bus_rdy_o),
	.rvalid_o   (rvalid_o),
	.irq_o      (irq_o),
	.intc_enb_i (u_intc.enb_q)
);

`default_nettype wire

/* verification/tb_mcoc_lite.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_mcoc_lite;

	localparam int MAX_CYCLES = 4000;	// Tests take roughly 300 cycles
	localparam int DRIVE_DLY  = 1;	// Input skew after the rising edge
	localparam int RD_LATENCY = 2;	// Accept edge to rvalid
	localparam int WAIT_LIMIT = 16;	// Ready and rvalid watchdog
	localparam int IRQ_LIMIT  = 13;	// Period 10 plus 3

	logic                    clk;
	logic                    rst_i;
	mcoc_bus_pkg::bus_req_t  bus_req_i;
	logic                    bus_rdy_o;
	mcoc_bus_pkg::bus_data_t rdata_o;
	logic                    rvalid_o;
	logic [7:0]              port_in_i;
	logic [7:0]              port_out_o;
	logic [7:0]              port_enb_o;
	logic [1:0]              ext_int_i;
	logic                    tim0_pwma_o;
	logic                    tim0_pwmb_o;
	logic                    tim1_pwma_o;
	logic                    tim1_pwmb_o;
	logic                    irq_o;
	int                      errors = 0;
	int                      checks = 0;
	int                      cycles = 0;

	mcoc_lite_top u_mcoc_lite_top (
		.clk         (clk),
		.rst_i       (rst_i),
		.bus_req_i   (bus_req_i),
		.bus_rdy_o   (bus_rdy_o),
		.rdata_o     (rdata_o),
		.rvalid_o    (rvalid_o),
		.port_in_i   (port_in_i),
		.port_out_o  (port_out_o),
		.port_enb_o  (port_enb_o),
		.ext_int_i   (ext_int_i),
		.tim0_pwma_o (tim0_pwma_o),
		.tim0_pwmb_o (tim0_pwmb_o),
		.tim1_pwma_o (tim1_pwma_o),
		.tim1_pwmb_o (tim1_pwmb_o),
		.irq_o       (irq_o)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;	// 10 ns period
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout, run stopped after %0d cycles", cycles);
			$display("Test FAILED");
			$finish;
		end
	end

	function automatic mcoc_bus_pkg::bus_addr_t reg_addr(input mcoc_bus_pkg::bus_addr_t base,
			input mcoc_bus_pkg::reg_ofs_t ofs);
		return {base[15:4], ofs};	// Blocks are 16 words apart
	endfunction

	function automatic logic pwm_level(input int idx, input logic chan_b);
		if (idx == 0) begin
			return chan_b ? tim0_pwmb_o : tim0_pwma_o;
		end
		return chan_b ? tim1_pwmb_o : tim1_pwma_o;
	endfunction

	task automatic check_data(input string name, input mcoc_bus_pkg::bus_data_t got,
			input mcoc_bus_pkg::bus_data_t exp);
		checks++;
		if (got !== exp) begin
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_port(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	task automatic drive_req(input logic rd, input logic wr,
			input mcoc_bus_pkg::bus_addr_t addr, input mcoc_bus_pkg::bus_data_t wdata);
		bus_req_i.rd    = rd;
		bus_req_i.wr    = wr;
		bus_req_i.addr  = addr;
		bus_req_i.wdata = wdata;
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (!bus_rdy_o && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (!bus_rdy_o) begin
			$display("Bus ready stayed low for %0d cycles", n);
			errors++;
		end
	endtask

	task automatic wait_rvalid(output int waited);
		waited = 0;
		while (!rvalid_o && waited < WAIT_LIMIT) begin
			next_cycle();
			waited++;
		end
		if (!rvalid_o) begin
			$display("No read data returned within %0d cycles", WAIT_LIMIT);
			errors++;
		end
	endtask

	task automatic bus_write(input mcoc_bus_pkg::bus_addr_t addr,
			input mcoc_bus_pkg::bus_data_t data);
		wait_ready();
		drive_req(1'b0, 1'b1, addr, data);
		next_cycle();	// Accept edge
		drive_req(1'b0, 1'b0, '0, '0);
	endtask

	task automatic bus_read(input mcoc_bus_pkg::bus_addr_t addr,
			output mcoc_bus_pkg::bus_data_t data);
		int waited;
		wait_ready();
		drive_req(1'b1, 1'b0, addr, '0);
		next_cycle();
		drive_req(1'b0, 1'b0, '0, '0);
		wait_rvalid(waited);
		if (waited != RD_LATENCY) begin
			$display("Read of %h returned after %0d cycles instead of %0d", addr, waited,
				RD_LATENCY);
			errors++;
		end
		data = rdata_o;
	endtask

	// Two reads on consecutive edges
	task automatic bus_read_pair(input mcoc_bus_pkg::bus_addr_t addr0,
			input mcoc_bus_pkg::bus_addr_t addr1, output mcoc_bus_pkg::bus_data_t data0,
			output mcoc_bus_pkg::bus_data_t data1);
		int waited;
		wait_ready();
		drive_req(1'b1, 1'b0, addr0, '0);
		next_cycle();
		drive_req(1'b1, 1'b0, addr1, '0);
		next_cycle();
		drive_req(1'b0, 1'b0, '0, '0);
		wait_rvalid(waited);
		if (waited != RD_LATENCY - 1) begin	// Counted from the second accept
			$display("First of two reads returned after %0d cycles", waited + 1);
			errors++;
		end
		data0 = rdata_o;
		next_cycle();
		check_bit("rvalid_o second read", rvalid_o, 1'b1);
		data1 = rdata_o;
	endtask

	task automatic expect_read(input string name, input mcoc_bus_pkg::bus_addr_t addr,
			input mcoc_bus_pkg::bus_data_t exp);
		mcoc_bus_pkg::bus_data_t data;
		bus_read(addr, data);
		check_data(name, data, exp);
	endtask

	task automatic test_reset_id();
		mcoc_bus_pkg::bus_data_t d0;
		mcoc_bus_pkg::bus_data_t d1;
		check_bit("bus_rdy_o", bus_rdy_o, 1'b0);	// First cycle after release
		check_bit("rvalid_o", rvalid_o, 1'b0);
		check_bit("irq_o", irq_o, 1'b0);
		check_bit("tim0_pwma_o", tim0_pwma_o, 1'b0);
		check_bit("tim0_pwmb_o", tim0_pwmb_o, 1'b0);
		check_bit("tim1_pwma_o", tim1_pwma_o, 1'b0);
		check_bit("tim1_pwmb_o", tim1_pwmb_o, 1'b0);
		check_port("port_out_o", port_out_o, 8'h00);
		check_port("port_enb_o", port_enb_o, 8'h00);
		next_cycle();
		check_bit("bus_rdy_o", bus_rdy_o, 1'b1);
		expect_read("IDCODE", reg_addr(mcoc_bus_pkg::IDRG_BASE, 4'd0), 16'h1150);
		expect_read("VERSNO", reg_addr(mcoc_bus_pkg::IDRG_BASE, 4'd1), 16'h0148);
		expect_read("unmapped read", 16'h1234, 16'h0000);
		expect_read("unused ID offset", reg_addr(mcoc_bus_pkg::IDRG_BASE, 4'd7), 16'h0000);
		bus_read_pair(reg_addr(mcoc_bus_pkg::IDRG_BASE, 4'd1),
			reg_addr(mcoc_bus_pkg::IDRG_BASE, 4'd0), d0, d1);
		check_data("pair read VERSNO", d0, 16'h0148);
		check_data("pair read IDCODE", d1, 16'h1150);
	endtask

	task automatic test_gpio();
		logic [7:0] pat;
		for (int i = 0; i < 3; i++) begin
			pat = 8'($urandom);
			bus_write(reg_addr(mcoc_bus_pkg::PORT_BASE, mcoc_periph_pkg::PORT_OUT), {8'h00, pat});
			next_cycle();
			check_port("port_out_o", port_out_o, pat);
			expect_read("PORT_OUT", reg_addr(mcoc_bus_pkg::PORT_BASE, mcoc_periph_pkg::PORT_OUT),
				{8'h00, pat});
			pat = 8'($urandom);
			bus_write(reg_addr(mcoc_bus_pkg::PORT_BASE, mcoc_periph_pkg::PORT_ENB), {8'h00, pat});
			next_cycle();
			check_port("port_enb_o", port_enb_o, pat);
			pat = 8'($urandom);
			port_in_i = pat;
			next_cycle();	// Read samples on the third edge after the pin change
			expect_read("PORT_IN", reg_addr(mcoc_bus_pkg::PORT_BASE, mcoc_periph_pkg::PORT_IN),
				{8'h00, pat});
		end
	endtask

	task automatic test_timer_pwm(input int idx);
		mcoc_bus_pkg::bus_addr_t base;
		int                      high_a;
		int                      high_b;
		base = (idx == 0) ? mcoc_bus_pkg::TIM0_BASE : mcoc_bus_pkg::TIM1_BASE;
		bus_write(reg_addr(base, mcoc_periph_pkg::TIM_PERIOD), 16'd9);
		bus_write(reg_addr(base, mcoc_periph_pkg::TIM_CMPA), 16'd3);
		bus_write(reg_addr(base, mcoc_periph_pkg::TIM_CMPB), 16'd7);
		expect_read($sformatf("tim%0d PERIOD", idx), reg_addr(base, mcoc_periph_pkg::TIM_PERIOD),
			16'd9);
		bus_write(reg_addr(base, mcoc_periph_pkg::TIM_CTRL), 16'h0003);	// Clear and enable
		repeat (3) next_cycle();
		high_a = 0;
		high_b = 0;
		repeat (10) begin	// One full period
			if (pwm_level(idx, 1'b0)) begin
				high_a++;
			end
			if (pwm_level(idx, 1'b1)) begin
				high_b++;
			end
			next_cycle();
		end
		check_count($sformatf("tim%0d pwma high cycles", idx), high_a, 3);
		check_count($sformatf("tim%0d pwmb high cycles", idx), high_b, 7);
		bus_write(reg_addr(base, mcoc_periph_pkg::TIM_CTRL), 16'h0000);
		repeat (2) next_cycle();
		check_bit($sformatf("tim%0d pwma stopped", idx), pwm_level(idx, 1'b0), 1'b0);
		check_bit($sformatf("tim%0d pwmb stopped", idx), pwm_level(idx, 1'b1), 1'b0);
	endtask

	task automatic test_timer_irq();
		mcoc_bus_pkg::bus_data_t flags;
		int                      waited;
		bus_write(reg_addr(mcoc_bus_pkg::INTC_BASE, mcoc_periph_pkg::INTC_FLAG), 16'h00FF);
		bus_write(reg_addr(mcoc_bus_pkg::INTC_BASE, mcoc_periph_pkg::INTC_ENB), 16'h0004);
		bus_write(reg_addr(mcoc_bus_pkg::TIM0_BASE, mcoc_periph_pkg::TIM_CTRL), 16'h0003);
		waited = 0;
		while (!irq_o && waited < IRQ_LIMIT) begin
			next_cycle();
			waited++;
		end
		if (!irq_o) begin
			$display("irq_o did not rise within %0d cycles of the timer start", IRQ_LIMIT);
			errors++;
		end
		expect_read("INTC_VEC timer 0", reg_addr(mcoc_bus_pkg::INTC_BASE,
			mcoc_periph_pkg::INTC_VEC), 16'd2);
		bus_write(reg_addr(mcoc_bus_pkg::TIM0_BASE, mcoc_periph_pkg::TIM_CTRL), 16'h0000);
		repeat (3) next_cycle();	// Last event pulse settles
		bus_write(reg_addr(mcoc_bus_pkg::INTC_BASE, mcoc_periph_pkg::INTC_FLAG), 16'h0004);
		repeat (2) next_cycle();
		check_bit("irq_o after flag clear", irq_o, 1'b0);
		bus_read(reg_addr(mcoc_bus_pkg::INTC_BASE, mcoc_periph_pkg::INTC_FLAG), flags);
		check_bit("INTC_FLAG bit 2", flags[2], 1'b0);
		bus_write(reg_addr(mcoc_bus_pkg::INTC_BASE, mcoc_periph_pkg::INTC_ENB), 16'h0000);
		bus_write(reg_addr(mcoc_bus_pkg::INTC_BASE, mcoc_periph_pkg::INTC_FLAG), 16'h00FF);
	endtask

	task automatic test_ext_irq();
		mcoc_bus_pkg::bus_data_t flags;
		ext_int_i[1] = 1'b1;
		repeat (6) begin	// Masked, so no request
			next_cycle();
			check_bit("irq_o with factor 1 masked", irq_o, 1'b0);
		end
		expect_read("INTC_FLAG ext 1", reg_addr(mcoc_bus_pkg::INTC_BASE,
			mcoc_periph_pkg::INTC_FLAG), 16'h0002);
		bus_write(reg_addr(mcoc_bus_pkg::INTC_BASE, mcoc_periph_pkg::INTC_ENB), 16'h0002);
		repeat (2) next_cycle();
		check_bit("irq_o with factor 1 enabled", irq_o, 1'b1);
		expect_read("INTC_VEC ext 1", reg_addr(mcoc_bus_pkg::INTC_BASE,
			mcoc_periph_pkg::INTC_VEC), 16'd1);
		bus_write(reg_addr(mcoc_bus_pkg::INTC_BASE, mcoc_periph_pkg::INTC_ENB), 16'h0022);
		bus_write(reg_addr(mcoc_bus_pkg::TIM1_BASE, mcoc_periph_pkg::TIM_CTRL), 16'h0003);
		repeat (14) next_cycle();	// One wrap of timer 1 sets flag 5
		bus_write(reg_addr(mcoc_bus_pkg::TIM1_BASE, mcoc_periph_pkg::TIM_CTRL), 16'h0000);
		repeat (3) next_cycle();
		bus_read(reg_addr(mcoc_bus_pkg::INTC_BASE, mcoc_periph_pkg::INTC_FLAG), flags);
		check_bit("INTC_FLAG bit 1", flags[1], 1'b1);
		check_bit("INTC_FLAG bit 5", flags[5], 1'b1);
		expect_read("INTC_VEC flags 1 and 5", reg_addr(mcoc_bus_pkg::INTC_BASE,
			mcoc_periph_pkg::INTC_VEC), 16'd1);
		bus_write(reg_addr(mcoc_bus_pkg::INTC_BASE, mcoc_periph_pkg::INTC_FLAG), 16'h0002);
		expect_read("INTC_VEC flag 5 left", reg_addr(mcoc_bus_pkg::INTC_BASE,
			mcoc_periph_pkg::INTC_VEC), 16'd5);
		ext_int_i = 2'b00;
		bus_write(reg_addr(mcoc_bus_pkg::INTC_BASE, mcoc_periph_pkg::INTC_ENB), 16'h0000);
		bus_write(reg_addr(mcoc_bus_pkg::INTC_BASE, mcoc_periph_pkg::INTC_FLAG), 16'h00FF);
	endtask

	initial begin
		rst_i     = 1'b1;
		bus_req_i = '0;
		port_in_i = '0;
		ext_int_i = '0;
		void'($urandom(7));
		repeat (2) @(posedge clk);	// Reset for 2 cycles
		#DRIVE_DLY;
		rst_i = 1'b0;
		test_reset_id();
		test_gpio();
		test_timer_pwm(0);
		test_timer_pwm(1);
		test_timer_irq();
		test_ext_irq();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* mcoc_lite.f */
source/mcoc_bus_pkg.sv
source/mcoc_periph_pkg.sv
source/mcoc_bus_decode.sv
source/mcoc_timer_pwm.sv
source/mcoc_gpio_port.sv
source/mcoc_intc.sv
source/mcoc_bus_return.sv
source/mcoc_lite_top.sv
verification/mcoc_lite_sva.sv
verification/tb_mcoc_lite.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mcoc_lite
FILELIST  ?= mcoc_lite.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	@grep -q "Test OK" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
